// File: sim.f
hw/utim_pkg.sv
hw/utim_reg_if.sv
hw/utim_req_queue.sv
hw/utim_ctrl.sv
hw/utim_main_counter.sv
hw/utim_comparator.sv
hw/utim64_top.sv
tests/tb_clock.sv
tests/utim64_tb.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module utim64_tb \
		-Mdir obj_dir -o utim64_sim

run: build
	./obj_dir/utim64_sim | tee sim.log
	grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module utim64_tb

clean:
	rm -rf obj_dir sim.log

// File: tests/utim64_tb.sv
`timescale 1ns/10ps
`default_nettype none

module utim64_tb import utim_pkg::*; ();

	localparam int QUEUE_DEPTH = 4;

	typedef enum {CHK_EQ, CHK_GT, CHK_PERIODIC} chk_e;

	// For periodic reads, data holds the period
	typedef struct {
		utim_op_e op;
		utim_reg_e addr;
		logic [31:0] data;
		logic [31:0] exp;
		chk_e kind;
		int wait_cyc;
	} step_t;

	wire iTIMER_CLOCK;
	wire inRESET;
	logic req_valid;
	utim_op_e req_op;
	utim_reg_e req_addr;
	logic [31:0] req_data;
	wire credit_return;
	wire resp_valid;
	wire [31:0] resp_data;
	wire [UTIM_NUM_CMP-1:0] irq;

	step_t steps[$];
	step_t pending[$];
	int credits;
	int errors;
	int pulses [UTIM_NUM_CMP];
	int limit_cycles;
	integer seed;

	tb_clock u_clock (
		.iTIMER_CLOCK(iTIMER_CLOCK),
		.inRESET(inRESET)
	);

	utim64_top #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_dut (
		.iTIMER_CLOCK(iTIMER_CLOCK),
		.inRESET(inRESET),
		.req_valid(req_valid),
		.req_op(req_op),
		.req_addr(req_addr),
		.req_data(req_data),
		.credit_return(credit_return),
		.resp_valid(resp_valid),
		.resp_data(resp_data),
		.irq(irq)
	);

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
			errors = errors + 1;
		end
	endtask

	task automatic queue_write(input utim_reg_e addr, input logic [31:0] data,
		input int wait_cyc = 0);
		steps.push_back('{OP_WRITE, addr, data, 32'd0, CHK_EQ, wait_cyc});
	endtask

	task automatic queue_read(input utim_reg_e addr, input logic [31:0] exp,
		input chk_e kind = CHK_EQ, input logic [31:0] period = 32'd0);
		steps.push_back('{OP_READ, addr, period, exp, kind, 0});
	endtask

	function automatic logic [31:0] fill_word(input int a);
		return {8'(a), 8'(a * 29), 8'(~a), 8'h5c ^ 8'(a)};
	endfunction

	task automatic build_table();
		// Everything is zero out of reset
		for (int a = 0; a <= int'(REG_C3_HI); a++) begin
			queue_read(utim_reg_e'(a), 32'd0);
		end
		// Back-to-back burst over all registers, counter stopped
		for (int a = int'(REG_MCFG); a <= int'(REG_C3_HI); a++) begin
			queue_write(utim_reg_e'(a), fill_word(a));
		end
		for (int a = int'(REG_MCFG); a <= int'(REG_C3_HI); a++) begin
			queue_read(utim_reg_e'(a), fill_word(a));
		end
		for (int a = int'(REG_MCFG); a <= int'(REG_C3_HI); a++) begin
			queue_write(utim_reg_e'(a), 32'd0);
		end
		// Counter halves, then a short run
		queue_write(REG_MCNT_LO, 32'h1234_0000);
		queue_write(REG_MCNT_HI, 32'h0000_0001);
		queue_read(REG_MCNT_LO, 32'h1234_0000);
		queue_read(REG_MCNT_HI, 32'h0000_0001);
		queue_write(REG_MCFG, 32'd1, 30);
		queue_write(REG_MCFG, 32'd0);
		queue_read(REG_MCNT_LO, 32'h1234_0000, CHK_GT);
		queue_read(REG_MCNT_HI, 32'h0000_0001);
		// One-shot on ch0 with irq_en, ch1 without
		queue_write(REG_MCNT_LO, 32'h0000_0100);
		queue_write(REG_MCNT_HI, 32'd0);
		queue_write(REG_C0_LO, 32'h0000_0120);
		queue_write(REG_C0CFG, 32'h7);
		queue_write(REG_C1_LO, 32'h0000_0120);
		queue_write(REG_C1CFG, 32'h5);
		queue_write(REG_MCFG, 32'd1, 60);
		queue_write(REG_MCFG, 32'd0);
		queue_read(REG_C0CFG, 32'h6);
		queue_read(REG_C1CFG, 32'h4);
		// Periodic ch2, period equals the first compare value
		queue_write(REG_MCNT_LO, 32'd0);
		queue_write(REG_C2_LO, 32'h0000_0010);
		queue_write(REG_C2CFG, 32'hf);
		queue_write(REG_MCFG, 32'd1, 100);
		queue_write(REG_MCFG, 32'd0);
		queue_read(REG_C2_LO, 32'h0000_0010, CHK_PERIODIC, 32'h0000_0010);
		queue_read(REG_C2_HI, 32'd0);
		queue_write(REG_C2CFG, 32'd0);
		// ch3 in 32-bit mode, high words differ
		queue_write(REG_MCNT_LO, 32'h0000_0200);
		queue_write(REG_MCNT_HI, 32'h0000_0005);
		queue_write(REG_C3_LO, 32'h0000_0220);
		queue_write(REG_C3CFG, 32'h3);
		queue_write(REG_MCFG, 32'd1, 60);
		queue_write(REG_MCFG, 32'd0);
		queue_read(REG_C3CFG, 32'h2);
	endtask

	task automatic send(input step_t s);
		while (credits <= 0) begin
			@(negedge iTIMER_CLOCK);
		end
		req_valid = 1'b1;
		req_op = s.op;
		req_addr = s.addr;
		req_data = s.data;
		credits = credits - 1;
		if (s.op == OP_READ) begin
			pending.push_back(s);
		end
		@(negedge iTIMER_CLOCK);
		req_valid = 1'b0;
	endtask

	// Credits and irq pulses seen on the active edge
	always @(posedge iTIMER_CLOCK) begin
		if (inRESET) begin
			if (credit_return) begin
				credits = credits + 1;
				if (credits > QUEUE_DEPTH) begin
					$display("Host credit count went above the queue depth at %0t", $time);
					errors = errors + 1;
				end
			end
			for (int c = 0; c < UTIM_NUM_CMP; c++) begin
				if (irq[c]) begin
					pulses[c] = pulses[c] + 1;
				end
			end
		end
	end

	always @(posedge iTIMER_CLOCK) begin : resp_check
		step_t s;
		int ch;
		if (inRESET && resp_valid) begin
			if (pending.size() == 0) begin
				$display("A response arrived with no read outstanding at %0t", $time);
				errors = errors + 1;
			end else begin
				s = pending.pop_front();
				case (s.kind)
					CHK_GT: check_value({s.addr.name(), " above written value"},
						32'(resp_data > s.exp), 32'd1);
					CHK_PERIODIC: begin
						ch = (int'(s.addr) - int'(REG_C0CFG)) / 3;
						check_value(s.addr.name(), resp_data, s.exp + 32'(pulses[ch]) * s.data);
					end
					default: check_value(s.addr.name(), resp_data, s.exp);
				endcase
			end
		end
	end

	initial begin : watchdog
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge iTIMER_CLOCK);
		$display("Run timed out after %0d cycles with reads still outstanding", limit_cycles);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin : main
		int max_wait;
		int gap;
		req_valid = 1'b0;
		req_op = OP_READ;
		req_addr = REG_MCFG;
		req_data = 32'd0;
		credits = QUEUE_DEPTH;
		errors = 0;
		seed = 32'h8e4096f3;
		foreach (pulses[c]) begin
			pulses[c] = 0;
		end
		build_table();
		max_wait = 0;
		foreach (steps[i]) begin
			if (steps[i].wait_cyc > max_wait) begin
				max_wait = steps[i].wait_cyc;
			end
		end
		limit_cycles = steps.size() * (QUEUE_DEPTH + max_wait + 20);
		wait (inRESET === 1'b1);
		@(negedge iTIMER_CLOCK);
		foreach (steps[i]) begin
			send(steps[i]);
			gap = $unsigned($random(seed)) % 3;
			repeat (steps[i].wait_cyc + gap) @(negedge iTIMER_CLOCK);
		end
		while (pending.size() != 0) begin
			@(negedge iTIMER_CLOCK);
		end
		repeat (4) @(negedge iTIMER_CLOCK);
		check_value("host credits", 32'(credits), 32'(QUEUE_DEPTH));
		check_value("ch0 irq pulses", 32'(pulses[0]), 32'd1);
		check_value("ch1 irq pulses", 32'(pulses[1]), 32'd0);
		check_value("ch2 has irq pulses", 32'(pulses[2] > 0), 32'd1);
		check_value("ch3 irq pulses", 32'(pulses[3]), 32'd1);
		$display("Run complete with %0d error(s)", errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 20,
	parameter int RESET_CYCLES = 4
) (
	output logic iTIMER_CLOCK,
	output logic inRESET
);

	initial begin
		iTIMER_CLOCK = 1'b0;
		forever begin
			#(PERIOD_NS / 2) iTIMER_CLOCK = ~iTIMER_CLOCK;
		end
	end

	// Release on a falling edge, clear of the active edge
	initial begin
		inRESET = 1'b0;
		repeat (RESET_CYCLES) @(posedge iTIMER_CLOCK);
		@(negedge iTIMER_CLOCK);
		inRESET = 1'b1;
	end

endmodule

`default_nettype wire

// File: hw/utim64_top.sv
`timescale 1ns/10ps
`default_nettype none

module utim64_top import utim_pkg::*; #(
	parameter int unsigned QUEUE_DEPTH = 4
) (
	input wire iTIMER_CLOCK,
	input wire inRESET,
	input wire req_valid,
	input utim_op_e req_op,
	input utim_reg_e req_addr,
	input wire [31:0] req_data,
	output logic credit_return,
	output logic resp_valid,
	output logic [31:0] resp_data,
	output logic [UTIM_NUM_CMP-1:0] irq
);

	logic q_empty;
	logic q_pop;
	utim_op_e q_head_op;
	utim_reg_e q_head_addr;
	logic [31:0] q_head_data;
	logic cnt_working;
	logic [63:0] cnt_value;

	utim_reg_if u_bus ();

	utim_req_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_queue (
		.iTIMER_CLOCK(iTIMER_CLOCK),
		.inRESET(inRESET),
		.push(req_valid),
		.push_op(req_op),
		.push_addr(req_addr),
		.push_data(req_data),
		.pop(q_pop),
		.empty(q_empty),
		.head_op(q_head_op),
		.head_addr(q_head_addr),
		.head_data(q_head_data),
		.credit_return(credit_return)
	);

	utim_ctrl u_ctrl (
		.iTIMER_CLOCK(iTIMER_CLOCK),
		.inRESET(inRESET),
		.empty(q_empty),
		.head_op(q_head_op),
		.head_addr(q_head_addr),
		.head_data(q_head_data),
		.pop(q_pop),
		.bus(u_bus.control),
		.resp_valid(resp_valid),
		.resp_data(resp_data)
	);

	utim_main_counter u_counter (
		.iTIMER_CLOCK(iTIMER_CLOCK),
		.inRESET(inRESET),
		.bus(u_bus.unit),
		.working(cnt_working),
		.count(cnt_value)
	);

	// One comparator per irq line
	for (genvar g = 0; g < UTIM_NUM_CMP; g++) begin : g_cmp
		utim_comparator #(
			.CH(g)
		) u_cmp (
			.iTIMER_CLOCK(iTIMER_CLOCK),
			.inRESET(inRESET),
			.bus(u_bus.unit),
			.working(cnt_working),
			.count(cnt_value),
			.irq(irq[g])
		);
	end

endmodule

`default_nettype wire

// File: hw/utim_comparator.sv
`timescale 1ns/10ps
`default_nettype none

module utim_comparator import utim_pkg::*; #(
	parameter int unsigned CH = 0
) (
	input wire iTIMER_CLOCK,
	input wire inRESET,
	utim_reg_if.unit bus,
	input wire working,
	input wire [63:0] count,
	output logic irq
);

	logic [31:0] cfg;
	logic [63:0] cmp_val;
	logic [63:0] period;
	logic wr_hit;
	logic wr_cfg;
	logic wr_lo;
	logic wr_hi;
	logic hit_value;
	logic match;

	// Unit 0 is the main counter
	assign wr_hit = bus.wr_en && bus.wr_sel[CH+1];
	assign wr_cfg = wr_hit && (bus.wr_field == FIELD_CFG);
	assign wr_lo = wr_hit && (bus.wr_field == FIELD_LO);
	assign wr_hi = wr_hit && (bus.wr_field == FIELD_HI);

	assign hit_value = cfg[CCFG_MODE64_BIT] ? (count == cmp_val)
		: (count[31:0] == cmp_val[31:0]);
	assign match = cfg[CCFG_ENA_BIT] && working && hit_value;

	assign bus.cmp_cfg[CH] = cfg;
	assign bus.cmp_val[CH] = cmp_val;

	always_ff @(posedge iTIMER_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			cfg <= '0;
			cmp_val <= '0;
			period <= '0;
			irq <= 1'b0;
		end else begin
			irq <= match && cfg[CCFG_IRQEN_BIT];

			// One-shot disarms itself unless software rewrites config
			if (wr_cfg) begin
				cfg <= bus.wr_data;
			end else if (match && !cfg[CCFG_PERIODIC_BIT]) begin
				cfg[CCFG_ENA_BIT] <= 1'b0;
			end

			// Compare writes also set the period
			if (wr_lo) begin
				cmp_val[31:0] <= bus.wr_data;
				period[31:0] <= bus.wr_data;
			end else if (wr_hi) begin
				cmp_val[63:32] <= bus.wr_data;
				period[63:32] <= bus.wr_data;
			end else if (match && cfg[CCFG_PERIODIC_BIT]) begin
				cmp_val <= cmp_val + period;
			end
		end
	end

	// irq_en only changes through a config write, so it still holds during the pulse
	a_irq_needs_en: assert property (@(posedge iTIMER_CLOCK) disable iff (!inRESET)
		irq |-> (cfg[CCFG_IRQEN_BIT] || $past(wr_cfg)))
		else $error("channel %0d raised irq without irq_en", CH);

endmodule

`default_nettype wire

// File: hw/utim_main_counter.sv
`timescale 1ns/10ps
`default_nettype none

module utim_main_counter import utim_pkg::*; (
	input wire iTIMER_CLOCK,
	input wire inRESET,
	utim_reg_if.unit bus,
	output logic working,
	output logic [63:0] count
);

	logic [31:0] cfg;
	logic wr_hit;

	// Unit 0 on the register bus
	assign wr_hit = bus.wr_en && bus.wr_sel[0];

	assign working = cfg[MCFG_ENA_BIT];

	assign bus.mcnt_cfg = cfg;
	assign bus.mcnt_count = count;

	always_ff @(posedge iTIMER_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			cfg <= '0;
			count <= '0;
		end else begin
			if (wr_hit && (bus.wr_field == FIELD_CFG)) begin
				cfg <= bus.wr_data;
			end
			// Half-word write beats the increment
			if (wr_hit && (bus.wr_field == FIELD_LO)) begin
				count <= {count[63:32], bus.wr_data};
			end else if (wr_hit && (bus.wr_field == FIELD_HI)) begin
				count <= {bus.wr_data, count[31:0]};
			end else if (working) begin
				count <= count + 64'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/utim_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module utim_ctrl import utim_pkg::*; (
	input wire iTIMER_CLOCK,
	input wire inRESET,
	input wire empty,
	input utim_op_e head_op,
	input utim_reg_e head_addr,
	input wire [31:0] head_data,
	output logic pop,
	utim_reg_if.control bus,
	output logic resp_valid,
	output logic [31:0] resp_data
);

	localparam int unsigned UNIT_IDX_W = $clog2(UTIM_NUM_UNITS);
	localparam int unsigned CMP_IDX_W = $clog2(UTIM_NUM_CMP);

	logic addr_hit;
	logic [UNIT_IDX_W-1:0] unit_idx;
	logic [CMP_IDX_W-1:0] cmp_idx;
	utim_field_e field;
	logic read_pop;
	logic [31:0] cfg_sel;
	logic [63:0] val_sel;
	logic [31:0] rd_word;

	// Never stalls, the host is bounded by its credits
	assign pop = !empty;
	assign read_pop = pop && (head_op == OP_READ);

	// Address to unit and field
	always_comb begin
		addr_hit = (head_addr <= REG_C3_HI);
		unit_idx = UNIT_IDX_W'(head_addr / UTIM_FIELDS_PER_UNIT);
		field = utim_field_e'(2'(head_addr % UTIM_FIELDS_PER_UNIT));
		cmp_idx = CMP_IDX_W'(unit_idx - 1'b1);
	end

	// Write strobe to the register bus
	always_comb begin
		bus.wr_en = pop && (head_op == OP_WRITE) && addr_hit;
		bus.wr_sel = '0;
		if (addr_hit) begin
			bus.wr_sel[unit_idx] = 1'b1;
		end
		bus.wr_field = field;
		bus.wr_data = head_data;
	end

	// Readback lane select
	always_comb begin
		if (unit_idx == '0) begin
			cfg_sel = bus.mcnt_cfg;
			val_sel = bus.mcnt_count;
		end else begin
			cfg_sel = bus.cmp_cfg[cmp_idx];
			val_sel = bus.cmp_val[cmp_idx];
		end
		case (field)
			FIELD_CFG: rd_word = cfg_sel;
			FIELD_LO: rd_word = val_sel[31:0];
			FIELD_HI: rd_word = val_sel[63:32];
			default: rd_word = '0;
		endcase
		// Hole at the top of the map reads as zero
		if (!addr_hit) begin
			rd_word = '0;
		end
	end

	always_ff @(posedge iTIMER_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= read_pop;
		end
	end

	// Data sampled in the pop cycle
	always_ff @(posedge iTIMER_CLOCK) begin
		if (read_pop) begin
			resp_data <= rd_word;
		end
	end

	a_wr_sel_onehot: assert property (@(posedge iTIMER_CLOCK) disable iff (!inRESET)
		bus.wr_en |-> $onehot(bus.wr_sel))
		else $error("register write without a single target unit");

endmodule

`default_nettype wire

// File: hw/utim_req_queue.sv
`timescale 1ns/10ps
`default_nettype none

module utim_req_queue import utim_pkg::*; #(
	parameter int unsigned QUEUE_DEPTH = 4
) (
	input wire iTIMER_CLOCK,
	input wire inRESET,
	input wire push,
	input utim_op_e push_op,
	input utim_reg_e push_addr,
	input wire [31:0] push_data,
	input wire pop,
	output logic empty,
	output utim_op_e head_op,
	output utim_reg_e head_addr,
	output logic [31:0] head_data,
	output logic credit_return
);

	localparam int unsigned PTR_W = $clog2(QUEUE_DEPTH);

	utim_op_e mem_op [QUEUE_DEPTH];
	utim_reg_e mem_addr [QUEUE_DEPTH];
	logic [31:0] mem_data [QUEUE_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic full;
	logic do_push;
	logic do_pop;

	assign full = (count == (PTR_W+1)'(QUEUE_DEPTH));
	assign empty = (count == '0);
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// One credit back per entry taken
	assign credit_return = do_pop;

	assign head_op = mem_op[rd_ptr];
	assign head_addr = mem_addr[rd_ptr];
	assign head_data = mem_data[rd_ptr];

	always_ff @(posedge iTIMER_CLOCK) begin
		if (do_push) begin
			mem_op[wr_ptr] <= push_op;
			mem_addr[wr_ptr] <= push_addr;
			mem_data[wr_ptr] <= push_data;
		end
	end

	// Pointers wrap naturally, depth is a power of two
	always_ff @(posedge iTIMER_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
		end
	end

	// Host must respect its credits
	a_no_overflow: assert property (@(posedge iTIMER_CLOCK) disable iff (!inRESET)
		push |-> !full)
		else $error("request pushed into a full queue, entry dropped");

	a_no_underflow: assert property (@(posedge iTIMER_CLOCK) disable iff (!inRESET)
		pop |-> !empty)
		else $error("pop from an empty request queue");

endmodule

`default_nettype wire

// File: hw/utim_reg_if.sv
`timescale 1ns/10ps
`default_nettype none

interface utim_reg_if import utim_pkg::*; ();

	logic wr_en;
	logic [UTIM_NUM_UNITS-1:0] wr_sel;
	utim_field_e wr_field;
	logic [31:0] wr_data;

	// Readback lanes
	logic [31:0] mcnt_cfg;
	logic [63:0] mcnt_count;
	logic [31:0] cmp_cfg [UTIM_NUM_CMP];
	logic [63:0] cmp_val [UTIM_NUM_CMP];

	modport control (
		output wr_en, wr_sel, wr_field, wr_data,
		input mcnt_cfg, mcnt_count, cmp_cfg, cmp_val
	);

	modport unit (
		input wr_en, wr_sel, wr_field, wr_data,
		output mcnt_cfg, mcnt_count, cmp_cfg, cmp_val
	);

endinterface

`default_nettype wire

// File: hw/utim_pkg.sv
`default_nettype none

package utim_pkg;

	// Request opcode
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} utim_op_e;

	// Register map, three words per unit
	typedef enum logic [3:0] {
		REG_MCFG    = 4'd0,
		REG_MCNT_LO = 4'd1,
		REG_MCNT_HI = 4'd2,
		REG_C0CFG   = 4'd3,
		REG_C0_LO   = 4'd4,
		REG_C0_HI   = 4'd5,
		REG_C1CFG   = 4'd6,
		REG_C1_LO   = 4'd7,
		REG_C1_HI   = 4'd8,
		REG_C2CFG   = 4'd9,
		REG_C2_LO   = 4'd10,
		REG_C2_HI   = 4'd11,
		REG_C3CFG   = 4'd12,
		REG_C3_LO   = 4'd13,
		REG_C3_HI   = 4'd14
	} utim_reg_e;

	// Word within one unit
	typedef enum logic [1:0] {
		FIELD_CFG = 2'd0,
		FIELD_LO  = 2'd1,
		FIELD_HI  = 2'd2
	} utim_field_e;

	localparam int unsigned UTIM_NUM_CMP = 4;
	// Main counter plus the compare channels
	localparam int unsigned UTIM_NUM_UNITS = 5;
	localparam int unsigned UTIM_FIELDS_PER_UNIT = 3;

	// Main config bits
	localparam int unsigned MCFG_ENA_BIT = 0;

	// Channel config bits
	localparam int unsigned CCFG_ENA_BIT = 0;
	localparam int unsigned CCFG_IRQEN_BIT = 1;
	localparam int unsigned CCFG_MODE64_BIT = 2;
	localparam int unsigned CCFG_PERIODIC_BIT = 3;

endpackage

`default_nettype wire
